//--- Bender.yml
package:
  name: cpu

sources:
  - files:
      - cpuPkg.sv
      - fetchStage.sv
      - decodeStage.sv
      - registerFile.sv
      - executeStage.sv
      - memoryStage.sv
      - cpuTop.sv
  - target: simulation
    files:
      - cpuTb.sv

//--- cpuPkg.sv
package cpuPkg;

	localparam int xlen = 32;
	localparam int addrLen = 32;
	localparam logic [addrLen-1:0] resetVector = 32'h8000_0000;

	typedef logic [xlen-1:0] word_t;
	typedef logic [addrLen-1:0] addr_t;
	typedef logic [4:0] regIdx_t;
	typedef logic [2:0] memLen_t; // access size in bytes, one bit per size

	localparam memLen_t len1 = 3'b001;
	localparam memLen_t len2 = 3'b010;
	localparam memLen_t len4 = 3'b100;

	// major opcodes, inst[6:0]
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opReg = 7'b0110011;

	localparam logic [6:0] f7Base = 7'b0000000;
	localparam logic [6:0] f7Alt = 7'b0100000; // sub, sra

	localparam word_t ebreakWord = 32'h0010_0073;

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluSll = 4'd2,
		aluSlt = 4'd3,
		aluSltu = 4'd4,
		aluXor = 4'd5,
		aluSrl = 4'd6,
		aluSra = 4'd7,
		aluOr = 4'd8,
		aluAnd = 4'd9,
		aluPassB = 4'd10 // lui
	} aluOp_t;

	typedef enum logic [1:0] {
		srcPlus4 = 2'b00,
		srcBranch = 2'b01,
		srcJumpReg = 2'b10,
		srcHold = 2'b11
	} pcSrc_t;

	typedef enum logic [1:0] {
		wbAlu = 2'b00,
		wbMem = 2'b01,
		wbPcPlus4 = 2'b10,
		wbPcBranch = 2'b11 // auipc takes the branch adder result
	} wbSel_t;

	typedef enum logic [1:0] {
		jmpNone = 2'b00,
		jmpJal = 2'b01,
		jmpJalr = 2'b10
	} jmp_t;

endpackage

//--- cpuTb.sv
module cpuTb;

	localparam int progMax = 256;
	localparam int dmemBytes = 1024;
	localparam cpuPkg::addr_t dataBase = 32'h8000_1000;
	localparam cpuPkg::word_t badWord = 32'h0010_b023; // sd x1, 0(x1) is outside the subset

	logic clk = 1'b0;
	logic rst;
	logic badPhase; // feed badWord instead of the program
	cpuPkg::word_t inst;
	cpuPkg::word_t dataRData;
	cpuPkg::addr_t pc;
	cpuPkg::addr_t dataAddr;
	cpuPkg::word_t dataWData;
	logic [3:0] dataWMask;
	logic memWrite;
	logic memRead;
	logic invalid;
	logic ebreak;

	// program table and the expected pc trace and store table built with it
	cpuPkg::word_t imem [progMax];
	int progLen;
	cpuPkg::addr_t pcExp [progMax];
	logic ldExp [progMax]; // executed slot is a load
	int pcCount;
	cpuPkg::addr_t stAddr [progMax];
	logic [3:0] stMask [progMax];
	cpuPkg::word_t stData [progMax];
	int stCount;
	cpuPkg::word_t shadow [32]; // register values as the program should leave them
	logic [7:0] dmem [dmemBytes];

	cpuTop UUT (
		.clk(clk), .rst(rst), .inst(inst), .dataRData(dataRData),
		.pc(pc), .dataAddr(dataAddr), .dataWData(dataWData), .dataWMask(dataWMask),
		.memWrite(memWrite), .memRead(memRead), .invalid(invalid), .ebreak(ebreak)
	);

	always #2 clk = ~clk;

	function automatic cpuPkg::word_t memWord(input cpuPkg::addr_t a);
		cpuPkg::addr_t off;
		off = {a[31:2], 2'b00} - dataBase;
		if ($isunknown(a) || off >= dmemBytes) return '0;
		return {dmem[off + 3], dmem[off + 2], dmem[off + 1], dmem[off]};
	endfunction

	always_comb begin
		if (!rst || $isunknown(pc)) inst = '0; // word 0 while in reset
		else if (badPhase) inst = badWord;
		else if (pc - cpuPkg::resetVector < 4 * progLen) begin
			inst = imem[(pc - cpuPkg::resetVector) >> 2];
		end
		else inst = '0;
	end

	always_comb dataRData = memWord(dataAddr);

	always @(posedge clk) begin
		if (rst && memWrite && dataAddr - dataBase < dmemBytes) begin
			for (int b = 0; b < 4; b++) begin
				if (dataWMask[b]) dmem[dataAddr - dataBase + b] <= dataWData[8*b +: 8];
			end
		end
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic checkAddr(input string name, input cpuPkg::addr_t got,
			input cpuPkg::addr_t exp);
		if (got !== exp) failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkWord(input string name, input cpuPkg::word_t got,
			input cpuPkg::word_t exp);
		if (got !== exp) failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkMask(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) failRun($sformatf("mismatch %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic fillData();
		logic [31:0] state;
		cpuPkg::word_t w;
		state = 32'd45118;
		for (int i = 0; i < dmemBytes / 4; i++) begin
			state = lcgNext(state);
			w = state ^ (dataBase + 4 * i); // mix in the full word address
			for (int b = 0; b < 4; b++) dmem[4 * i + b] = w[8*b +: 8];
		end
	endtask

	function automatic cpuPkg::word_t laneMask(input logic [3:0] m);
		return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
	endfunction

	// RV32I result for funct3, alt selects sub and sra
	function automatic cpuPkg::word_t refAlu(input logic [2:0] f3, input logic alt,
			input cpuPkg::word_t a, input cpuPkg::word_t b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return cpuPkg::word_t'($signed(a) < $signed(b));
			3'b011: return cpuPkg::word_t'(a < b);
			3'b100: return a ^ b;
			3'b101: return alt ? cpuPkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic cpuPkg::word_t iType(input int imm, input int rs1, input logic [2:0] f3,
			input int rd, input logic [6:0] op);
		return {12'(imm), 5'(rs1), f3, 5'(rd), op};
	endfunction

	function automatic cpuPkg::word_t sType(input int imm, input int rs2, input int rs1,
			input logic [2:0] f3);
		logic [11:0] i;
		i = 12'(imm);
		return {i[11:5], 5'(rs2), 5'(rs1), f3, i[4:0], cpuPkg::opStore};
	endfunction

	function automatic cpuPkg::addr_t curPc();
		return cpuPkg::resetVector + 4 * progLen;
	endfunction

	task automatic emit(input cpuPkg::word_t w); // an instruction on the executed path
		pcExp[pcCount] = curPc();
		ldExp[pcCount] = 1'b0;
		pcCount++;
		imem[progLen] = w;
		progLen++;
	endtask

	task automatic skipWords(input int n);
		for (int i = 0; i < n; i++) begin
			imem[progLen] = '0; // invalid if ever fetched
			progLen++;
		end
	endtask

	task automatic setReg(input int rd, input cpuPkg::word_t v);
		if (rd != 0) shadow[rd] = v;
	endtask

	task automatic opR(input logic [2:0] f3, input logic alt, input int rd, input int rs1,
			input int rs2);
		emit({alt ? cpuPkg::f7Alt : cpuPkg::f7Base, 5'(rs2), 5'(rs1), f3, 5'(rd), cpuPkg::opReg});
		setReg(rd, refAlu(f3, alt, shadow[rs1], shadow[rs2]));
	endtask

	task automatic opI(input logic [2:0] f3, input int rd, input int rs1, input int imm);
		emit(iType(imm, rs1, f3, rd, cpuPkg::opImm));
		setReg(rd, refAlu(f3, 1'b0, shadow[rs1], cpuPkg::word_t'(imm)));
	endtask

	task automatic upper(input logic [6:0] op, input int rd, input logic [19:0] imm);
		cpuPkg::word_t u;
		u = {imm, 12'b0};
		if (op == cpuPkg::opAuipc) u = u + curPc();
		emit({imm, 5'(rd), op});
		setReg(rd, u);
	endtask

	task automatic loadOp(input logic [2:0] f3, input int rd, input int rs1, input int off);
		cpuPkg::addr_t a;
		cpuPkg::word_t lane;
		cpuPkg::word_t v;
		a = shadow[rs1] + cpuPkg::word_t'(off);
		lane = memWord(a) >> (8 * a[1:0]);
		case (f3)
			3'b000: v = {{24{lane[7]}}, lane[7:0]};
			3'b001: v = {{16{lane[15]}}, lane[15:0]};
			3'b100: v = {24'b0, lane[7:0]};
			3'b101: v = {16'b0, lane[15:0]};
			default: v = lane;
		endcase
		emit(iType(off, rs1, f3, rd, cpuPkg::opLoad));
		ldExp[pcCount - 1] = 1'b1;
		setReg(rd, v);
	endtask

	task automatic storeOp(input logic [2:0] f3, input int rs2, input int rs1, input int off);
		cpuPkg::addr_t a;
		logic [3:0] m;
		a = shadow[rs1] + cpuPkg::word_t'(off);
		case (f3)
			3'b000: m = 4'b0001 << a[1:0];
			3'b001: m = 4'b0011 << a[1:0];
			default: m = 4'b1111;
		endcase
		stAddr[stCount] = {a[31:2], 2'b00}; // word address, lanes go by mask
		stMask[stCount] = m;
		stData[stCount] = (shadow[rs2] << (8 * a[1:0])) & laneMask(m);
		stCount++;
		emit(sType(off, rs2, rs1, f3));
	endtask

	task automatic branchEq(input int rs1, input int rs2, input int skip);
		logic [12:0] off;
		off = 13'(4 * (skip + 1));
		emit({off[12], off[10:5], 5'(rs2), 5'(rs1), 3'b000, off[4:1], off[11], cpuPkg::opBranch});
		if (shadow[rs1] == shadow[rs2]) skipWords(skip); // taken
	endtask

	task automatic jumpLink(input int rd, input int skip);
		logic [20:0] off;
		off = 21'(4 * (skip + 1));
		setReg(rd, curPc() + 4);
		emit({off[20], off[10:1], off[11], off[19:12], 5'(rd), cpuPkg::opJal});
		skipWords(skip);
	endtask

	task automatic jumpReg(input int rd, input int rs1, input int off);
		cpuPkg::addr_t target;
		target = (shadow[rs1] + cpuPkg::word_t'(off)) & ~cpuPkg::addr_t'(1);
		setReg(rd, curPc() + 4);
		emit(iType(off, rs1, 3'b000, rd, cpuPkg::opJalr));
		skipWords(int'((target - curPc()) / 4));
	endtask

	task automatic buildProgram();
		int soff; // next free word of the store area
		logic [2:0] loadF3 [5];
		logic [2:0] lf;
		loadF3 = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
		for (int i = 0; i < 32; i++) shadow[i] = '0;
		progLen = 0;
		pcCount = 0;
		stCount = 0;
		soff = 0;
		upper(cpuPkg::opLui, 1, 20'h80001); // x1 points at the LCG fill
		opI(3'b000, 2, 1, 256); // x2 store area
		opI(3'b000, 3, 0, -1234);
		opI(3'b000, 4, 0, 1447);
		for (int f = 0; f < 8; f++) begin
			opR(3'(f), 1'b0, 5, 3, 4);
			storeOp(3'b010, 5, 2, soff);
			opR(3'(f), 1'b0, 6, 4, 3); // swapped operands
			storeOp(3'b010, 6, 2, soff + 4);
			soff += 8;
		end
		opR(3'b000, 1'b1, 5, 3, 4); // sub
		storeOp(3'b010, 5, 2, soff);
		opR(3'b101, 1'b1, 6, 3, 4); // sra of a negative value
		storeOp(3'b010, 6, 2, soff + 4);
		soff += 8;
		for (int f = 0; f < 8; f++) begin
			if (f != 1 && f != 5) begin
				opI(3'(f), 7, 3, -21);
				storeOp(3'b010, 7, 2, soff);
				soff += 4;
			end
		end
		upper(cpuPkg::opLui, 8, 20'habcde);
		storeOp(3'b010, 8, 2, soff);
		upper(cpuPkg::opAuipc, 8, 20'h12345);
		storeOp(3'b010, 8, 2, soff + 4);
		soff += 8;
		for (int k = 0; k < 5; k++) begin
			lf = loadF3[k];
			for (int o = 0; o < 4; o++) begin
				if (o % (1 << lf[1:0]) == 0) begin
					loadOp(lf, 9, 1, 16 * k + o);
					storeOp(3'b010, 9, 2, soff);
					soff += 4;
				end
			end
		end
		upper(cpuPkg::opLui, 10, 20'h12345);
		opI(3'b000, 10, 10, 1656); // x10 = 12345678 hex
		for (int o = 0; o < 4; o++) storeOp(3'b000, 10, 2, 448 + o);
		storeOp(3'b001, 10, 2, 456);
		storeOp(3'b001, 10, 2, 458);
		opI(3'b000, 11, 0, 5);
		opI(3'b000, 12, 0, 5);
		branchEq(11, 12, 2); // taken
		branchEq(11, 3, 1); // not taken, falls into the next word
		opI(3'b000, 13, 0, 1);
		storeOp(3'b010, 13, 2, soff);
		jumpLink(14, 3);
		storeOp(3'b010, 14, 2, soff + 4);
		upper(cpuPkg::opAuipc, 15, 20'h0);
		jumpReg(16, 15, 21); // odd offset, bit 0 dropped
		storeOp(3'b010, 16, 2, soff + 8);
		emit(cpuPkg::ebreakWord);
	endtask

	task automatic applyReset(input logic nextBad);
		@(posedge clk);
		rst <= 1'b0;
		repeat (8) @(posedge clk);
		badPhase <= nextBad;
		rst <= 1'b1;
	endtask

	task automatic runProgram();
		int cycles;
		int limit;
		int pcIdx;
		int stIdx;
		logic done;
		cycles = 0;
		limit = 2 * progLen + 20;
		pcIdx = 0;
		stIdx = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) failRun("timeout, ebreak not reached within the cycle limit");
			if (pcIdx >= pcCount) failRun("program ran past the expected instruction trace");
			checkAddr("pc", pc, pcExp[pcIdx]);
			checkBit("memRead", memRead, ldExp[pcIdx]);
			pcIdx++;
			if (invalid) failRun("a program instruction was flagged invalid");
			if (memWrite) begin
				if (stIdx >= stCount) failRun("store issued beyond the expected store table");
				checkAddr("dataAddr", dataAddr, stAddr[stIdx]);
				checkMask("dataWMask", dataWMask, stMask[stIdx]);
				checkWord("dataWData", dataWData & laneMask(dataWMask), stData[stIdx]);
				stIdx++;
			end
			done = ebreak;
		end
		if (pcIdx != pcCount || stIdx != stCount) begin
			failRun($sformatf("ebreak after %0d of %0d instructions and %0d of %0d stores",
				pcIdx, pcCount, stIdx, stCount));
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	endtask

	initial begin
		rst = 1'b0;
		badPhase = 1'b1;
		fillData();
		buildProgram();
		applyReset(1'b1);
		repeat (4) begin // unsupported word, pc must hold at the reset vector
			@(negedge clk);
			checkAddr("pc", pc, cpuPkg::resetVector);
			if (!invalid) failRun("invalid was not raised for an unsupported word");
			if (memWrite) failRun("a store was issued for an unsupported word");
		end
		applyReset(1'b0);
		runProgram();
	end

endmodule

//--- cpuTop.sv
module cpuTop (
	input  logic clk,
	input  logic rst,
	input  cpuPkg::word_t inst,
	input  cpuPkg::word_t dataRData,
	output cpuPkg::addr_t pc,
	output cpuPkg::addr_t dataAddr,
	output cpuPkg::word_t dataWData,
	output logic [3:0] dataWMask,
	output logic memWrite,
	output logic memRead,
	output logic invalid,
	output logic ebreak
);

	cpuPkg::pcSrc_t pcSrc;
	cpuPkg::addr_t pcPlus4;
	cpuPkg::addr_t pcBranch;
	cpuPkg::word_t aluResult;

	cpuPkg::regIdx_t rs1, rs2, rd;
	cpuPkg::word_t imm;
	cpuPkg::aluOp_t aluOp;
	logic aluSrc;
	logic branch;
	cpuPkg::jmp_t jmp;
	logic regWrite;
	cpuPkg::memLen_t memLen;
	logic memSign;
	cpuPkg::wbSel_t wbSel;

	cpuPkg::word_t rData1, rData2;
	cpuPkg::word_t writeData; // writeback value into the register file

	fetchStage fetch (
		.clk(clk), .rst(rst),
		.pcSrc(pcSrc), .pcBranch(pcBranch), .aluResult(aluResult),
		.pc(pc), .pcPlus4(pcPlus4)
	);

	decodeStage decode (
		.inst(inst),
		.rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.aluOp(aluOp), .aluSrc(aluSrc), .branch(branch), .jmp(jmp),
		.regWrite(regWrite), .memWrite(memWrite), .memRead(memRead),
		.memLen(memLen), .memSign(memSign), .wbSel(wbSel),
		.invalid(invalid), .ebreak(ebreak)
	);

	registerFile regFile (
		.clk(clk), .rst(rst),
		.rs1(rs1), .rs2(rs2), .rd(rd),
		.regWrite(regWrite), .wData(writeData),
		.rData1(rData1), .rData2(rData2)
	);

	executeStage execute (
		.pc(pc), .rData1(rData1), .rData2(rData2), .imm(imm),
		.aluOp(aluOp), .aluSrc(aluSrc), .branch(branch), .jmp(jmp),
		.invalid(invalid), .ebreak(ebreak),
		.aluResult(aluResult), .pcBranch(pcBranch), .pcSrc(pcSrc)
	);

	memoryStage memory (
		.aluResult(aluResult), .rData2(rData2),
		.memLen(memLen), .memSign(memSign), .memRead(memRead), .wbSel(wbSel),
		.dataRData(dataRData), .pcPlus4(pcPlus4), .pcBranch(pcBranch),
		.dataAddr(dataAddr), .dataWData(dataWData), .dataWMask(dataWMask),
		.writeData(writeData)
	);

endmodule

//--- decodeStage.sv
module decodeStage (
	input  cpuPkg::word_t inst,
	output cpuPkg::regIdx_t rs1,
	output cpuPkg::regIdx_t rs2,
	output cpuPkg::regIdx_t rd,
	output cpuPkg::word_t imm,
	output cpuPkg::aluOp_t aluOp,
	output logic aluSrc,
	output logic branch,
	output cpuPkg::jmp_t jmp,
	output logic regWrite,
	output logic memWrite,
	output logic memRead,
	output cpuPkg::memLen_t memLen,
	output logic memSign,
	output cpuPkg::wbSel_t wbSel,
	output logic invalid,
	output logic ebreak
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic legal; // encoding inside the supported subset
	logic regWriteRaw;
	logic memWriteRaw;
	logic memReadRaw;
	cpuPkg::memLen_t sizeLen;
	cpuPkg::word_t immI, immS, immB, immU, immJ;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd = inst[11:7];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	// size field shared by loads and stores
	assign sizeLen = (funct3[1:0] == 2'b00) ? cpuPkg::len1 :
		(funct3[1:0] == 2'b01) ? cpuPkg::len2 : cpuPkg::len4;

	always_comb begin
		legal = 1'b0;
		aluOp = cpuPkg::aluAdd;
		aluSrc = 1'b0;
		branch = 1'b0;
		jmp = cpuPkg::jmpNone;
		regWriteRaw = 1'b0;
		memWriteRaw = 1'b0;
		memReadRaw = 1'b0;
		memLen = cpuPkg::len4;
		memSign = 1'b0;
		wbSel = cpuPkg::wbAlu;
		imm = '0;
		case (opcode)
			cpuPkg::opLui: begin
				legal = 1'b1;
				aluOp = cpuPkg::aluPassB;
				aluSrc = 1'b1;
				regWriteRaw = 1'b1;
				imm = immU;
			end
			cpuPkg::opAuipc: begin
				legal = 1'b1;
				regWriteRaw = 1'b1;
				wbSel = cpuPkg::wbPcBranch; // pc + imm from the target adder
				imm = immU;
			end
			cpuPkg::opJal: begin
				legal = 1'b1;
				regWriteRaw = 1'b1;
				jmp = cpuPkg::jmpJal;
				wbSel = cpuPkg::wbPcPlus4;
				imm = immJ;
			end
			cpuPkg::opJalr: begin
				legal = (funct3 == 3'b000);
				aluSrc = 1'b1;
				regWriteRaw = 1'b1;
				jmp = cpuPkg::jmpJalr;
				wbSel = cpuPkg::wbPcPlus4;
				imm = immI;
			end
			cpuPkg::opBranch: begin
				legal = (funct3 == 3'b000); // beq only
				aluOp = cpuPkg::aluSub;
				branch = 1'b1;
				imm = immB;
			end
			cpuPkg::opLoad: begin
				legal = (funct3[1:0] != 2'b11) && (funct3 != 3'b110);
				aluSrc = 1'b1;
				regWriteRaw = 1'b1;
				memReadRaw = 1'b1;
				memLen = sizeLen;
				memSign = !funct3[2]; // lbu, lhu zero extend
				wbSel = cpuPkg::wbMem;
				imm = immI;
			end
			cpuPkg::opStore: begin
				legal = !funct3[2] && (funct3[1:0] != 2'b11);
				aluSrc = 1'b1;
				memWriteRaw = 1'b1;
				memLen = sizeLen;
				imm = immS;
			end
			cpuPkg::opImm: begin
				legal = 1'b1;
				aluSrc = 1'b1;
				regWriteRaw = 1'b1;
				imm = immI;
				case (funct3)
					3'b000: aluOp = cpuPkg::aluAdd;
					3'b010: aluOp = cpuPkg::aluSlt;
					3'b011: aluOp = cpuPkg::aluSltu;
					3'b100: aluOp = cpuPkg::aluXor;
					3'b110: aluOp = cpuPkg::aluOr;
					3'b111: aluOp = cpuPkg::aluAnd;
					default: legal = 1'b0; // no immediate shifts
				endcase
			end
			cpuPkg::opReg: begin
				legal = (funct7 == cpuPkg::f7Base) || ((funct7 == cpuPkg::f7Alt) &&
					(funct3 == 3'b000 || funct3 == 3'b101));
				regWriteRaw = 1'b1;
				case (funct3)
					3'b000: begin
						if (funct7[5]) aluOp = cpuPkg::aluSub;
						else aluOp = cpuPkg::aluAdd;
					end
					3'b001: aluOp = cpuPkg::aluSll;
					3'b010: aluOp = cpuPkg::aluSlt;
					3'b011: aluOp = cpuPkg::aluSltu;
					3'b100: aluOp = cpuPkg::aluXor;
					3'b101: begin
						if (funct7[5]) aluOp = cpuPkg::aluSra;
						else aluOp = cpuPkg::aluSrl;
					end
					3'b110: aluOp = cpuPkg::aluOr;
					default: aluOp = cpuPkg::aluAnd;
				endcase
			end
			default: legal = 1'b0;
		endcase
	end

	assign ebreak = (inst == cpuPkg::ebreakWord);
	assign invalid = !legal && !ebreak;

	// nothing may change state on a bad word or on ebreak
	assign regWrite = regWriteRaw && !invalid && !ebreak;
	assign memWrite = memWriteRaw && !invalid && !ebreak;
	assign memRead = memReadRaw && !invalid && !ebreak;

	writeExclusive: assert final (!(regWrite && memWrite))
		else $error("regWrite and memWrite both set for inst %h", inst);

endmodule

//--- executeStage.sv
module executeStage (
	input  cpuPkg::addr_t pc,
	input  cpuPkg::word_t rData1,
	input  cpuPkg::word_t rData2,
	input  cpuPkg::word_t imm,
	input  cpuPkg::aluOp_t aluOp,
	input  logic aluSrc,
	input  logic branch,
	input  cpuPkg::jmp_t jmp,
	input  logic invalid,
	input  logic ebreak,
	output cpuPkg::word_t aluResult,
	output cpuPkg::addr_t pcBranch,
	output cpuPkg::pcSrc_t pcSrc
);

	cpuPkg::word_t srcA;
	cpuPkg::word_t srcB;
	logic [4:0] shamt;
	logic zero;

	// auipc does not go through the ALU, its pc + imm is the target adder
	assign srcA = rData1;
	assign srcB = aluSrc ? imm : rData2;
	assign shamt = srcB[4:0];

	always_comb begin
		case (aluOp)
			cpuPkg::aluAdd: aluResult = srcA + srcB;
			cpuPkg::aluSub: aluResult = srcA - srcB;
			cpuPkg::aluSll: aluResult = srcA << shamt;
			cpuPkg::aluSlt: begin
				aluResult = cpuPkg::word_t'($signed(srcA) < $signed(srcB));
			end
			cpuPkg::aluSltu: aluResult = cpuPkg::word_t'(srcA < srcB);
			cpuPkg::aluXor: aluResult = srcA ^ srcB;
			cpuPkg::aluSrl: aluResult = srcA >> shamt;
			cpuPkg::aluSra: aluResult = cpuPkg::word_t'($signed(srcA) >>> shamt);
			cpuPkg::aluOr: aluResult = srcA | srcB;
			cpuPkg::aluAnd: aluResult = srcA & srcB;
			cpuPkg::aluPassB: aluResult = srcB; // lui
			default: aluResult = '0;
		endcase
	end

	assign zero = (aluResult == '0); // beq compares by subtraction

	// jal, beq and auipc all use pc + imm
	assign pcBranch = pc + imm;

	always_comb begin
		if (invalid || ebreak) begin
			pcSrc = cpuPkg::srcHold;
		end else if (jmp == cpuPkg::jmpJalr) begin
			pcSrc = cpuPkg::srcJumpReg;
		end else if (jmp == cpuPkg::jmpJal || (branch && zero)) begin
			pcSrc = cpuPkg::srcBranch;
		end else begin
			pcSrc = cpuPkg::srcPlus4;
		end
	end

endmodule

//--- fetchStage.sv
module fetchStage (
	input  logic clk,
	input  logic rst,
	input  cpuPkg::pcSrc_t pcSrc,
	input  cpuPkg::addr_t pcBranch,
	input  cpuPkg::word_t aluResult,
	output cpuPkg::addr_t pc,
	output cpuPkg::addr_t pcPlus4
);

	cpuPkg::addr_t pcNext;

	assign pcPlus4 = pc + cpuPkg::addr_t'(4);

	always_comb begin
		case (pcSrc)
			cpuPkg::srcBranch: pcNext = pcBranch;
			cpuPkg::srcJumpReg: pcNext = {aluResult[cpuPkg::addrLen-1:1], 1'b0}; // jalr target
			cpuPkg::srcHold: pcNext = pc; // invalid or ebreak
			default: pcNext = pcPlus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= cpuPkg::resetVector;
		end else begin
			pc <= pcNext;
		end
	end

	// branch and jump targets come from the execute stage, so a bad
	// offset or jalr base would show up here one cycle later
	pcAligned: assert property (
		@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00
	) else $error("pc %h not word aligned", pc);

endmodule

//--- memoryStage.sv
module memoryStage (
	input  cpuPkg::word_t aluResult,
	input  cpuPkg::word_t rData2,
	input  cpuPkg::memLen_t memLen,
	input  logic memSign,
	input  logic memRead,
	input  cpuPkg::wbSel_t wbSel,
	input  cpuPkg::word_t dataRData,
	input  cpuPkg::addr_t pcPlus4,
	input  cpuPkg::addr_t pcBranch,
	output cpuPkg::addr_t dataAddr,
	output cpuPkg::word_t dataWData,
	output logic [3:0] dataWMask,
	output cpuPkg::word_t writeData
);

	logic [1:0] byteOff;
	logic [4:0] laneShift;
	cpuPkg::word_t laneData; // read word with the addressed byte in lane 0
	cpuPkg::word_t loadData;

	assign byteOff = aluResult[1:0];
	assign laneShift = {byteOff, 3'b000};
	assign dataAddr = {aluResult[cpuPkg::addrLen-1:2], 2'b00}; // word address, lanes by mask

	// store side
	assign dataWData = rData2 << laneShift;

	always_comb begin
		case (memLen)
			cpuPkg::len1: dataWMask = 4'b0001 << byteOff;
			cpuPkg::len2: dataWMask = 4'b0011 << byteOff;
			default: dataWMask = 4'b1111;
		endcase
	end

	// load side
	assign laneData = dataRData >> laneShift;

	always_comb begin
		if (!memRead) begin
			loadData = '0;
		end else begin
			case (memLen)
				cpuPkg::len1: loadData = {{24{memSign & laneData[7]}}, laneData[7:0]};
				cpuPkg::len2: loadData = {{16{memSign & laneData[15]}}, laneData[15:0]};
				default: loadData = dataRData;
			endcase
		end
	end

	always_comb begin
		case (wbSel)
			cpuPkg::wbMem: writeData = loadData;
			cpuPkg::wbPcPlus4: writeData = pcPlus4; // jal, jalr link
			cpuPkg::wbPcBranch: writeData = pcBranch;
			default: writeData = aluResult;
		endcase
	end

endmodule

//--- registerFile.sv
module registerFile (
	input  logic clk,
	input  logic rst,
	input  cpuPkg::regIdx_t rs1,
	input  cpuPkg::regIdx_t rs2,
	input  cpuPkg::regIdx_t rd,
	input  logic regWrite,
	input  cpuPkg::word_t wData,
	output cpuPkg::word_t rData1,
	output cpuPkg::word_t rData2
);

	cpuPkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && rd != '0) begin // x0 stays zero
			regs[rd] <= wData;
		end
	end

	// combinational reads, x0 forced to zero
	assign rData1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- verilog.f
cpuPkg.sv
fetchStage.sv
decodeStage.sv
registerFile.sv
executeStage.sv
memoryStage.sv
cpuTop.sv
cpuTb.sv
